//--- Bender.yml
package:
  name: vector_lane

sources:
  - logic/lane_pkg.sv
  - logic/lane_ifs.sv
  - logic/lane_sequencer.sv
  - logic/vector_regfile.sv
  - logic/vector_alu.sv
  - logic/lane_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/lane_tb.sv

//--- logic/lane_ifs.sv
`default_nettype none

// Element micro-op, sequencer to register file
interface uop_if #(
  parameter int unsigned NrVRegs   = lane_pkg::DefNrVRegs,
  parameter int unsigned VLenElems = lane_pkg::DefVLenElems
);
  import lane_pkg::*;

  localparam int unsigned RegW = (NrVRegs > 1) ? $clog2(NrVRegs) : 1;
  localparam int unsigned IdxW = (VLenElems > 1) ? $clog2(VLenElems) : 1;

  logic            valid;
  valu_op_e        op;
  logic [RegW-1:0] vd;
  logic [RegW-1:0] vs1;
  logic [RegW-1:0] vs2;
  logic [IdxW-1:0] idx;
  logic            last;

  modport seq (output valid, op, vd, vs1, vs2, idx, last);
  modport rf  (input  valid, op, vd, vs1, vs2, idx, last);
endinterface : uop_if

// Operands with their micro-op fields, register file to ALU
interface opd_if #(
  parameter int unsigned NrVRegs   = lane_pkg::DefNrVRegs,
  parameter int unsigned VLenElems = lane_pkg::DefVLenElems,
  parameter int unsigned ElemWidth = lane_pkg::DefElemWidth
);
  import lane_pkg::*;

  localparam int unsigned RegW = (NrVRegs > 1) ? $clog2(NrVRegs) : 1;
  localparam int unsigned IdxW = (VLenElems > 1) ? $clog2(VLenElems) : 1;

  logic                 valid;
  valu_op_e             op;
  logic [RegW-1:0]      vd;
  logic [IdxW-1:0]      idx;
  logic                 last;
  logic [ElemWidth-1:0] opa;
  logic [ElemWidth-1:0] opb;

  modport rf  (output valid, op, vd, idx, last, opa, opb);
  modport alu (input  valid, op, vd, idx, last, opa, opb);
endinterface : opd_if

// Write-back of one result element
interface wb_if #(
  parameter int unsigned NrVRegs   = lane_pkg::DefNrVRegs,
  parameter int unsigned VLenElems = lane_pkg::DefVLenElems,
  parameter int unsigned ElemWidth = lane_pkg::DefElemWidth
);
  localparam int unsigned RegW = (NrVRegs > 1) ? $clog2(NrVRegs) : 1;
  localparam int unsigned IdxW = (VLenElems > 1) ? $clog2(VLenElems) : 1;

  logic                 valid;
  logic [RegW-1:0]      vd;
  logic [IdxW-1:0]      idx;
  logic [ElemWidth-1:0] data;
  logic                 last;

  modport alu (output valid, vd, idx, data, last);
  modport rf  (input  valid, vd, idx, data, last);
  // Sequencer only watches for the final element
  modport mon (input  valid, last);
endinterface : wb_if

`default_nettype wire

//--- logic/lane_pkg.sv
`default_nettype none

package lane_pkg;

  //////////////////////////////
  // Vector opcodes
  //////////////////////////////

  // Element-wise integer operations of the lane
  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VSLL  = 3'd5,
    VSRL  = 3'd6,
    VMAXU = 3'd7
  } valu_op_e;

  //////////////////////////////
  // Sequencer states
  //////////////////////////////

  typedef enum logic {
    SEQ_IDLE  = 1'b0,
    SEQ_ISSUE = 1'b1
  } seq_state_e;

  //////////////////////////////
  // Default sizes
  //////////////////////////////

  // Number of vector registers
  localparam int unsigned DefNrVRegs   = 32'd8;
  // Elements per vector register
  localparam int unsigned DefVLenElems = 32'd8;
  // Element width in bits
  localparam int unsigned DefElemWidth = 32'd32;

endpackage : lane_pkg

`default_nettype wire

//--- logic/lane_sequencer.sv
`default_nettype none

module lane_sequencer #(
  parameter  int unsigned NrVRegs   = lane_pkg::DefNrVRegs,
  parameter  int unsigned VLenElems = lane_pkg::DefVLenElems,
  localparam int unsigned RegW      = (NrVRegs > 1) ? $clog2(NrVRegs) : 1,
  localparam int unsigned LenW      = $clog2(VLenElems + 1)
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               cmd_valid_i,
  input  wire lane_pkg::valu_op_e cmd_op_i,
  input  wire logic [RegW-1:0]    cmd_vd_i,
  input  wire logic [RegW-1:0]    cmd_vs1_i,
  input  wire logic [RegW-1:0]    cmd_vs2_i,
  input  wire logic [LenW-1:0]    cmd_vl_i,
  uop_if.seq                      uop,
  wb_if.mon                       wb,
  output logic                    busy_o,
  output logic                    done_o
);
  import lane_pkg::*;

  localparam int unsigned IdxW = (VLenElems > 1) ? $clog2(VLenElems) : 1;

  seq_state_e      state_q, state_d;
  logic            cmd_accept;
  logic            wb_last;
  logic            valid_q, last_q, done_q;
  logic [IdxW-1:0] idx_q;
  valu_op_e        op_q;
  logic [RegW-1:0] vd_q, vs1_q, vs2_q;
  logic [LenW-1:0] vl_q;

  assign cmd_accept = cmd_valid_i && (state_q == SEQ_IDLE);
  assign wb_last    = wb.valid && wb.last;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      SEQ_IDLE:  if (cmd_accept) state_d = SEQ_ISSUE;
      // Stay busy until the final element is written back
      SEQ_ISSUE: if (wb_last) state_d = SEQ_IDLE;
      default:   state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= wb_last;
      if (cmd_accept) begin
        valid_q <= 1'b1;
        idx_q   <= '0;
        last_q  <= (cmd_vl_i == LenW'(1));
      end else if (valid_q) begin
        if (last_q) begin
          valid_q <= 1'b0;
        end else begin
          idx_q  <= idx_q + 1'b1;
          // Next index is the final one
          last_q <= ((LenW'(idx_q) + LenW'(2)) == vl_q);
        end
      end
    end
  end

  // Instruction fields, held for the whole issue phase
  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      op_q  <= cmd_op_i;
      vd_q  <= cmd_vd_i;
      vs1_q <= cmd_vs1_i;
      vs2_q <= cmd_vs2_i;
      vl_q  <= cmd_vl_i;
    end
  end

  assign uop.valid = valid_q;
  assign uop.op    = op_q;
  assign uop.vd    = vd_q;
  assign uop.vs1   = vs1_q;
  assign uop.vs2   = vs2_q;
  assign uop.idx   = idx_q;
  assign uop.last  = last_q;

  assign busy_o = (state_q == SEQ_ISSUE);
  assign done_o = done_q;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Host starts instructions only while the lane is idle
  assert property (@(posedge clk_i) disable iff (!rst_ni) cmd_valid_i |-> !busy_o)
    else $error("instruction started while lane busy");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> (cmd_vl_i >= LenW'(1)) && (cmd_vl_i <= LenW'(VLenElems)))
    else $error("vector length out of range");

endmodule : lane_sequencer

`default_nettype wire

//--- logic/lane_top.sv
`default_nettype none

module lane_top #(
  parameter  int unsigned NrVRegs   = lane_pkg::DefNrVRegs,
  parameter  int unsigned VLenElems = lane_pkg::DefVLenElems,
  parameter  int unsigned ElemWidth = lane_pkg::DefElemWidth,
  localparam int unsigned RegW      = (NrVRegs > 1) ? $clog2(NrVRegs) : 1,
  localparam int unsigned IdxW      = (VLenElems > 1) ? $clog2(VLenElems) : 1,
  localparam int unsigned LenW      = $clog2(VLenElems + 1)
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Host write
  input  wire logic                 wr_en_i,
  input  wire logic [RegW-1:0]      wr_vreg_i,
  input  wire logic [IdxW-1:0]      wr_idx_i,
  input  wire logic [ElemWidth-1:0] wr_data_i,
  // Host read
  input  wire logic                 rd_req_i,
  input  wire logic [RegW-1:0]      rd_vreg_i,
  input  wire logic [IdxW-1:0]      rd_idx_i,
  output logic                      rd_valid_o,
  output logic [ElemWidth-1:0]      rd_data_o,
  // Instruction
  input  wire logic                 cmd_valid_i,
  input  wire lane_pkg::valu_op_e   cmd_op_i,
  input  wire logic [RegW-1:0]      cmd_vd_i,
  input  wire logic [RegW-1:0]      cmd_vs1_i,
  input  wire logic [RegW-1:0]      cmd_vs2_i,
  input  wire logic [LenW-1:0]      cmd_vl_i,
  // Status
  output logic                      busy_o,
  output logic                      done_o
);

  //////////////////////////////
  // Stage interfaces
  //////////////////////////////

  uop_if #(.NrVRegs(NrVRegs), .VLenElems(VLenElems)) uop ();
  opd_if #(.NrVRegs(NrVRegs), .VLenElems(VLenElems), .ElemWidth(ElemWidth)) opd ();
  wb_if  #(.NrVRegs(NrVRegs), .VLenElems(VLenElems), .ElemWidth(ElemWidth)) wb ();

  //////////////////////////////
  // Stages
  //////////////////////////////

  lane_sequencer #(
    .NrVRegs  (NrVRegs),
    .VLenElems(VLenElems)
  ) i_lane_sequencer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd_valid_i(cmd_valid_i),
    .cmd_op_i   (cmd_op_i),
    .cmd_vd_i   (cmd_vd_i),
    .cmd_vs1_i  (cmd_vs1_i),
    .cmd_vs2_i  (cmd_vs2_i),
    .cmd_vl_i   (cmd_vl_i),
    .uop        (uop.seq),
    .wb         (wb.mon),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

  vector_regfile #(
    .NrVRegs  (NrVRegs),
    .VLenElems(VLenElems),
    .ElemWidth(ElemWidth)
  ) i_vector_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_en_i   (wr_en_i),
    .wr_vreg_i (wr_vreg_i),
    .wr_idx_i  (wr_idx_i),
    .wr_data_i (wr_data_i),
    .rd_req_i  (rd_req_i),
    .rd_vreg_i (rd_vreg_i),
    .rd_idx_i  (rd_idx_i),
    .uop       (uop.rf),
    .opd       (opd.rf),
    .wb        (wb.rf),
    .rd_valid_o(rd_valid_o),
    .rd_data_o (rd_data_o)
  );

  vector_alu #(
    .NrVRegs  (NrVRegs),
    .VLenElems(VLenElems),
    .ElemWidth(ElemWidth)
  ) i_vector_alu (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .opd   (opd.alu),
    .wb    (wb.alu)
  );

endmodule : lane_top

`default_nettype wire

//--- logic/vector_alu.sv
`default_nettype none

module vector_alu #(
  parameter int unsigned NrVRegs   = lane_pkg::DefNrVRegs,
  parameter int unsigned VLenElems = lane_pkg::DefVLenElems,
  parameter int unsigned ElemWidth = lane_pkg::DefElemWidth
) (
  input wire logic clk_i,
  input wire logic rst_ni,
  opd_if.alu       opd,
  wb_if.alu        wb
);
  import lane_pkg::*;

  localparam int unsigned RegW = (NrVRegs > 1) ? $clog2(NrVRegs) : 1;
  localparam int unsigned IdxW = (VLenElems > 1) ? $clog2(VLenElems) : 1;
  localparam int unsigned ShW  = (ElemWidth > 1) ? $clog2(ElemWidth) : 1;

  logic [ShW-1:0]       shamt;
  logic [ElemWidth-1:0] result;
  logic [ElemWidth-1:0] data_q;
  logic [RegW-1:0]      vd_q;
  logic [IdxW-1:0]      idx_q;
  logic                 valid_q, last_q;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Only the low bits of opb count as shift amount
  assign shamt = opd.opb[ShW-1:0];

  always_comb begin
    unique case (opd.op)
      VADD:    result = opd.opa + opd.opb;
      VSUB:    result = opd.opa - opd.opb;
      VAND:    result = opd.opa & opd.opb;
      VOR:     result = opd.opa | opd.opb;
      VXOR:    result = opd.opa ^ opd.opb;
      VSLL:    result = opd.opa << shamt;
      VSRL:    result = opd.opa >> shamt;
      // Unsigned compare
      VMAXU:   result = (opd.opa > opd.opb) ? opd.opa : opd.opb;
      default: result = '0;
    endcase
  end

  //////////////////////////////
  // Write-back register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    data_q <= result;
    vd_q   <= opd.vd;
    idx_q  <= opd.idx;
    last_q <= opd.last;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= opd.valid;
    end
  end

  assign wb.valid = valid_q;
  assign wb.vd    = vd_q;
  assign wb.idx   = idx_q;
  assign wb.data  = data_q;
  assign wb.last  = last_q;

endmodule : vector_alu

`default_nettype wire

//--- logic/vector_regfile.sv
`default_nettype none

module vector_regfile #(
  parameter  int unsigned NrVRegs   = lane_pkg::DefNrVRegs,
  parameter  int unsigned VLenElems = lane_pkg::DefVLenElems,
  parameter  int unsigned ElemWidth = lane_pkg::DefElemWidth,
  localparam int unsigned RegW      = (NrVRegs > 1) ? $clog2(NrVRegs) : 1,
  localparam int unsigned IdxW      = (VLenElems > 1) ? $clog2(VLenElems) : 1
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Host write
  input  wire logic                 wr_en_i,
  input  wire logic [RegW-1:0]      wr_vreg_i,
  input  wire logic [IdxW-1:0]      wr_idx_i,
  input  wire logic [ElemWidth-1:0] wr_data_i,
  // Host read
  input  wire logic                 rd_req_i,
  input  wire logic [RegW-1:0]      rd_vreg_i,
  input  wire logic [IdxW-1:0]      rd_idx_i,
  uop_if.rf                         uop,
  opd_if.rf                         opd,
  wb_if.rf                          wb,
  output logic                      rd_valid_o,
  output logic [ElemWidth-1:0]      rd_data_o
);
  import lane_pkg::*;

  localparam int unsigned NrElems = NrVRegs * VLenElems;
  localparam int unsigned AddrW   = (NrElems > 1) ? $clog2(NrElems) : 1;

  logic [ElemWidth-1:0] mem_q [NrElems];

  logic [AddrW-1:0]     raddr_a, raddr_b, waddr;
  logic [ElemWidth-1:0] rdata_a_q, rdata_b_q, wdata;
  logic                 we;
  logic                 opd_valid_q, opd_last_q, rd_valid_q;
  valu_op_e             opd_op_q;
  logic [RegW-1:0]      opd_vd_q;
  logic [IdxW-1:0]      opd_idx_q;

  // Flat element address of vreg[idx]
  function automatic logic [AddrW-1:0] elem_addr(input logic [RegW-1:0] vreg,
                                                 input logic [IdxW-1:0] idx);
    return AddrW'(vreg) * AddrW'(VLenElems) + AddrW'(idx);
  endfunction

  //////////////////////////////
  // Ports
  //////////////////////////////

  // Port A is shared with host reads, micro-ops win
  assign raddr_a = uop.valid ? elem_addr(uop.vs1, uop.idx) : elem_addr(rd_vreg_i, rd_idx_i);
  assign raddr_b = elem_addr(uop.vs2, uop.idx);

  // Single write port
  assign we    = wb.valid || wr_en_i;
  assign waddr = wb.valid ? elem_addr(wb.vd, wb.idx) : elem_addr(wr_vreg_i, wr_idx_i);
  assign wdata = wb.valid ? wb.data : wr_data_i;

  always_ff @(posedge clk_i) begin
    if (we) begin
      mem_q[waddr] <= wdata;
    end
    rdata_a_q <= mem_q[raddr_a];
    rdata_b_q <= mem_q[raddr_b];
    // Micro-op fields follow their operands
    opd_op_q  <= uop.op;
    opd_vd_q  <= uop.vd;
    opd_idx_q <= uop.idx;
    opd_last_q <= uop.last;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opd_valid_q <= 1'b0;
      rd_valid_q  <= 1'b0;
    end else begin
      opd_valid_q <= uop.valid;
      rd_valid_q  <= rd_req_i;
    end
  end

  assign opd.valid = opd_valid_q;
  assign opd.op    = opd_op_q;
  assign opd.vd    = opd_vd_q;
  assign opd.idx   = opd_idx_q;
  assign opd.last  = opd_last_q;
  assign opd.opa   = rdata_a_q;
  assign opd.opb   = rdata_b_q;

  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = rdata_a_q;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Host writes only while no instruction is in flight
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(wr_en_i && wb.valid))
    else $error("host write collides with write-back");

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(rd_req_i && uop.valid))
    else $error("host read collides with operand read");

endmodule : vector_regfile

`default_nettype wire

//--- include/lane_tb_model.svh
`ifndef LANE_TB_MODEL_SVH
`define LANE_TB_MODEL_SVH

//////////////////////////////
// Register-file model
//////////////////////////////

// Expected contents, by register and element
logic [ElemWidth-1:0] model_mem [NrVRegs][VLenElems];

// Expected result of one element operation
function automatic logic [ElemWidth-1:0] model_alu(input valu_op_e             op,
                                                  input logic [ElemWidth-1:0] a,
                                                  input logic [ElemWidth-1:0] b);
  int unsigned sh;
  // Shift amount wraps at the element width
  sh = b % ElemWidth;
  case (op)
    VADD:    return a + b;
    VSUB:    return a + ~b + 1'b1;
    VAND:    return a & b;
    VOR:     return a | b;
    VXOR:    return a ^ b;
    VSLL:    return a << sh;
    VSRL:    return a >> sh;
    VMAXU:   return (a >= b) ? a : b;
    default: return 'x;
  endcase
endfunction

// Applies one instruction to the model using the old source values
task automatic model_exec(input valu_op_e op, input int unsigned vd, input int unsigned vs1,
                          input int unsigned vs2, input int unsigned vl);
  logic [ElemWidth-1:0] src_a [VLenElems];
  logic [ElemWidth-1:0] src_b [VLenElems];
  for (int i = 0; i < VLenElems; i++) begin
    src_a[i] = model_mem[vs1][i];
    src_b[i] = model_mem[vs2][i];
  end
  for (int i = 0; i < vl; i++) begin
    model_mem[vd][i] = model_alu(op, src_a[i], src_b[i]);
  end
endtask

`endif

//--- tests/lane_tb.sv
`default_nettype none

module lane_tb;
  import lane_pkg::*;

  localparam int unsigned NrVRegs     = DefNrVRegs;
  localparam int unsigned VLenElems   = DefVLenElems;
  localparam int unsigned ElemWidth   = DefElemWidth;
  localparam int unsigned RegW        = $clog2(NrVRegs);
  localparam int unsigned IdxW        = $clog2(VLenElems);
  localparam int unsigned LenW        = $clog2(VLenElems + 1);
  localparam int unsigned Timeout     = 100;
  localparam int unsigned NrRandomOps = 300;

  logic                 clk, rst_n;
  logic                 wr_en, rd_req, cmd_valid;
  logic [RegW-1:0]      wr_vreg, rd_vreg, cmd_vd, cmd_vs1, cmd_vs2;
  logic [IdxW-1:0]      wr_idx, rd_idx;
  logic [ElemWidth-1:0] wr_data, rd_data_o;
  logic [LenW-1:0]      cmd_vl;
  valu_op_e             cmd_op;
  logic                 rd_valid_o, busy_o, done_o;
  logic [31:0]          rng_state = 32'd3;

  `include "lane_tb_model.svh"

  lane_top i_lane_top (
    .clk_i(clk), .rst_ni(rst_n),
    .wr_en_i(wr_en), .wr_vreg_i(wr_vreg), .wr_idx_i(wr_idx), .wr_data_i(wr_data),
    .rd_req_i(rd_req), .rd_vreg_i(rd_vreg), .rd_idx_i(rd_idx),
    .rd_valid_o(rd_valid_o), .rd_data_o(rd_data_o),
    .cmd_valid_i(cmd_valid), .cmd_op_i(cmd_op), .cmd_vd_i(cmd_vd),
    .cmd_vs1_i(cmd_vs1), .cmd_vs2_i(cmd_vs2), .cmd_vl_i(cmd_vl),
    .busy_o(busy_o), .done_o(done_o)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    rng_state = xorshift32(rng_state);
    return rng_state % n;
  endfunction

  task automatic report_fail(input string msg);
    $display("SOME TESTS FAILED");
    $display("%s", msg);
    $fatal(1);
  endtask

  // Tasks start and end just after a falling edge
  task automatic write_elem(input int unsigned vreg, input int unsigned idx,
                            input logic [ElemWidth-1:0] data);
    wr_en   = 1'b1;
    wr_vreg = RegW'(vreg);
    wr_idx  = IdxW'(idx);
    wr_data = data;
    @(negedge clk);
    wr_en = 1'b0;
    model_mem[vreg][idx] = data;
  endtask

  task automatic read_check(input string name, input int unsigned vreg, input int unsigned idx);
    int unsigned n;
    rd_req  = 1'b1;
    rd_vreg = RegW'(vreg);
    rd_idx  = IdxW'(idx);
    @(negedge clk);
    rd_req = 1'b0;
    n = 0;
    while (!rd_valid_o && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    assert (rd_valid_o) else report_fail("timeout waiting for rd_valid_o");
    assert (n == 0)
      else report_fail($sformatf("mismatch read latency %s expected 1 actual %0d",
                                 name, n + 1));
    assert (rd_data_o === model_mem[vreg][idx])
      else report_fail($sformatf("mismatch %s v%0d[%0d] expected %h actual %h",
                                 name, vreg, idx, model_mem[vreg][idx], rd_data_o));
  endtask

  task automatic check_all_regs(input string name);
    for (int v = 0; v < NrVRegs; v++) begin
      for (int i = 0; i < VLenElems; i++) begin
        read_check(name, v, i);
      end
    end
  endtask

  task automatic run_cmd(input valu_op_e op, input int unsigned vd, input int unsigned vs1,
                         input int unsigned vs2, input int unsigned vl);
    int unsigned cyc;
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_vd    = RegW'(vd);
    cmd_vs1   = RegW'(vs1);
    cmd_vs2   = RegW'(vs2);
    cmd_vl    = LenW'(vl);
    @(negedge clk);
    cmd_valid = 1'b0;
    cyc = 1;
    while (!done_o && cyc < Timeout) begin
      assert (busy_o) else report_fail("busy_o low before done_o");
      @(negedge clk);
      cyc++;
    end
    assert (done_o) else report_fail("timeout waiting for done_o");
    assert (cyc == vl + 3)
      else report_fail($sformatf("mismatch done latency %s expected %0d actual %0d",
                                 op.name(), vl + 3, cyc));
    assert (!busy_o) else report_fail("busy_o still high together with done_o");
    model_exec(op, vd, vs1, vs2, vl);
    @(negedge clk);
    assert (!done_o) else report_fail("done_o high for more than one cycle");
  endtask

  function automatic valu_op_e rand_op();
    return valu_op_e'(rand_below(8));
  endfunction

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int unsigned v;
    valu_op_e    cur_op;
    rst_n     = 1'b0;
    wr_en     = 1'b0;
    wr_vreg   = '0;
    wr_idx    = '0;
    wr_data   = '0;
    rd_req    = 1'b0;
    rd_vreg   = '0;
    rd_idx    = '0;
    cmd_valid = 1'b0;
    cmd_op    = VADD;
    cmd_vd    = '0;
    cmd_vs1   = '0;
    cmd_vs2   = '0;
    cmd_vl    = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!busy_o && !done_o && !rd_valid_o)
      else report_fail("status outputs not low after reset");

    // Fill every element and read it back
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < VLenElems; i++) begin
        write_elem(r, i, rand_word());
      end
    end
    check_all_regs("readback");

    // Each opcode at full length
    for (int op = 0; op < 8; op++) begin
      cur_op = valu_op_e'(op);
      run_cmd(cur_op, rand_below(NrVRegs), rand_below(NrVRegs),
              rand_below(NrVRegs), VLenElems);
      check_all_regs($sformatf("full length %s", cur_op.name()));
    end

    // Partial lengths keep the tail
    repeat (8) begin
      run_cmd(rand_op(), rand_below(NrVRegs), rand_below(NrVRegs), rand_below(NrVRegs),
              1 + rand_below(VLenElems));
      check_all_regs("partial length");
    end

    // Destination overlaps a source
    for (int op = 0; op < 8; op++) begin
      v = rand_below(NrVRegs);
      run_cmd(valu_op_e'(op), v, v, rand_below(NrVRegs), VLenElems);
      v = rand_below(NrVRegs);
      run_cmd(valu_op_e'(op), v, rand_below(NrVRegs), v, 1 + rand_below(VLenElems));
      check_all_regs("overlap");
    end

    // Random mix of host accesses and instructions
    repeat (NrRandomOps) begin
      case (rand_below(3))
        0: write_elem(rand_below(NrVRegs), rand_below(VLenElems), rand_word());
        1: run_cmd(rand_op(), rand_below(NrVRegs), rand_below(NrVRegs), rand_below(NrVRegs),
                   1 + rand_below(VLenElems));
        default: read_check("random mix", rand_below(NrVRegs), rand_below(VLenElems));
      endcase
    end
    check_all_regs("random mix final");

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule : lane_tb

`default_nettype wire

//--- vlog.f
+incdir+include
logic/lane_pkg.sv
logic/lane_ifs.sv
logic/lane_sequencer.sv
logic/vector_regfile.sv
logic/vector_alu.sv
logic/lane_top.sv
tests/lane_tb.sv
